// File: design/soc_ctrl_pkg.sv
package soc_ctrl_pkg;

  // --------------------------------------------------
  // Widths and counts
  // --------------------------------------------------
  localparam int unsigned AddrWidth      = 32;
  localparam int unsigned DataWidth      = 32;
  localparam int unsigned NumHarts       = 2;
  localparam int unsigned DbgDelayCycles = 500;
  localparam int unsigned DbgCntWidth    = $clog2(DbgDelayCycles + 1);

  typedef logic [DataWidth-1:0] word_t;

  // --------------------------------------------------
  // Address map
  // --------------------------------------------------
  localparam int unsigned NumDevices = 2;

  typedef enum logic {
    DevClint = 1'b0,
    DevTrace = 1'b1
  } dev_idx_e;

  typedef struct packed {
    word_t idx;
    word_t start_addr;
    word_t end_addr;
  } addr_rule_t;

  localparam word_t ClintBase   = 32'h0200_0000;
  localparam word_t ClintLength = 32'h0000_C000;
  localparam word_t TraceBase   = 32'h1000_0000;
  localparam word_t TraceLength = 32'h0000_1000;

  // End address is exclusive
  localparam addr_rule_t AddrMap [NumDevices] = '{
    '{idx: word_t'(DevClint), start_addr: ClintBase, end_addr: ClintBase + ClintLength},
    '{idx: word_t'(DevTrace), start_addr: TraceBase, end_addr: TraceBase + TraceLength}
  };

  // CLINT register offsets
  localparam word_t MsipOffset     = 32'h0000_0000;
  localparam word_t MtimecmpOffset = 32'h0000_4000;
  localparam word_t MtimeLoOffset  = 32'h0000_BFF8;
  localparam word_t MtimeHiOffset  = 32'h0000_BFFC;

  // Trace config register offsets
  localparam word_t CoreSelOffset   = 32'h0000_0000;
  localparam word_t WatchAddrOffset = 32'h0000_0004;
  localparam word_t TrigEnOffset    = 32'h0000_0008;

  // Branch-target trace of one hart
  typedef struct packed {
    logic  valid;
    word_t pc;
  } hart_trace_t;

endpackage

// File: design/reg_bus_if.sv
interface reg_bus_if import soc_ctrl_pkg::*;;

  logic                 req;
  logic                 we;
  logic [AddrWidth-1:0] addr;
  word_t                wdata;
  word_t                rdata;

  modport host (
    output req,
    output we,
    output addr,
    output wdata,
    input  rdata
  );

  modport device (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

// File: design/addr_decoder.sv
module addr_decoder import soc_ctrl_pkg::*; (
  input  logic     clk_i,
  input  logic     ndmreset_n,
  input  logic     req_i,
  input  logic     we_i,
  input  word_t    addr_i,
  input  word_t    wdata_i,
  output word_t    rdata_o,
  output logic     decode_err_o,
  reg_bus_if.host  clint_bus,
  reg_bus_if.host  trace_bus
);

  logic     hit;
  dev_idx_e sel_d, sel_q;
  word_t    offset;
  logic     rd_pending_q;

  // Rule match, last matching rule wins
  always_comb begin
    hit    = 1'b0;
    sel_d  = DevClint;
    offset = '0;
    for (int i = 0; i < NumDevices; i++) begin
      if (addr_i >= AddrMap[i].start_addr && addr_i < AddrMap[i].end_addr) begin
        hit    = 1'b1;
        sel_d  = dev_idx_e'(AddrMap[i].idx[0]);
        offset = addr_i - AddrMap[i].start_addr;
      end
    end
  end

  assign clint_bus.req   = req_i & hit & (sel_d == DevClint);
  assign clint_bus.we    = we_i;
  assign clint_bus.addr  = offset;
  assign clint_bus.wdata = wdata_i;

  assign trace_bus.req   = req_i & hit & (sel_d == DevTrace);
  assign trace_bus.we    = we_i;
  assign trace_bus.addr  = offset;
  assign trace_bus.wdata = wdata_i;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rd_pending_q <= 1'b0;
      sel_q        <= DevClint;
      decode_err_o <= 1'b0;
    end else begin
      rd_pending_q <= req_i & ~we_i & hit;
      sel_q        <= sel_d;
      decode_err_o <= req_i & ~hit;
    end
  end

  // Read return one cycle after the request
  assign rdata_o = !rd_pending_q       ? '0 :
                   sel_q == DevClint ? clint_bus.rdata : trace_bus.rdata;

endmodule

// File: design/clint_timer.sv
module clint_timer import soc_ctrl_pkg::*; (
  input  logic                clk_i,
  input  logic                ndmreset_n,
  input  logic                rtc_i,
  reg_bus_if.device           bus,
  output logic [NumHarts-1:0] timer_irq_o,
  output logic [NumHarts-1:0] ipi_o
);

  logic [1:0]          rtc_sync_q;
  logic                rtc_prev_q;
  logic                rtc_div_q;
  logic                rtc_edge;
  logic                mtime_tick;
  logic [63:0]         mtime_q;
  logic [63:0]         mtimecmp_q [NumHarts];
  logic [NumHarts-1:0] msip_q;
  logic                wr;
  word_t               rdata_d;

  // --------------------------------------------------
  // RTC sync, edge detect and divide by two
  // --------------------------------------------------
  assign rtc_edge   = rtc_sync_q[1] & ~rtc_prev_q;
  assign mtime_tick = rtc_edge & rtc_div_q;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_sync_q <= '0;
      rtc_prev_q <= 1'b0;
      rtc_div_q  <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[0], rtc_i};
      rtc_prev_q <= rtc_sync_q[1];
      if (rtc_edge) begin
        rtc_div_q <= ~rtc_div_q;
      end
    end
  end

  // --------------------------------------------------
  // Registers
  // --------------------------------------------------
  assign wr = bus.req & bus.we;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      mtime_q <= '0;
    end else if (wr && bus.addr == MtimeLoOffset) begin
      mtime_q[31:0] <= bus.wdata;
    end else if (wr && bus.addr == MtimeHiOffset) begin
      mtime_q[63:32] <= bus.wdata;
    end else if (mtime_tick) begin
      mtime_q <= mtime_q + 64'd1;
    end
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      msip_q <= '0;
      for (int h = 0; h < NumHarts; h++) begin
        mtimecmp_q[h] <= '1;
      end
    end else begin
      for (int h = 0; h < NumHarts; h++) begin
        if (wr && bus.addr == MsipOffset + word_t'(4 * h)) begin
          msip_q[h] <= bus.wdata[0];
        end
        if (wr && bus.addr == MtimecmpOffset + word_t'(8 * h)) begin
          mtimecmp_q[h][31:0] <= bus.wdata;
        end
        if (wr && bus.addr == MtimecmpOffset + word_t'(8 * h + 4)) begin
          mtimecmp_q[h][63:32] <= bus.wdata;
        end
      end
    end
  end

  // Unused offsets read as zero
  always_comb begin
    rdata_d = '0;
    if (bus.addr == MtimeLoOffset) rdata_d = mtime_q[31:0];
    if (bus.addr == MtimeHiOffset) rdata_d = mtime_q[63:32];
    for (int h = 0; h < NumHarts; h++) begin
      if (bus.addr == MsipOffset + word_t'(4 * h)) rdata_d = word_t'(msip_q[h]);
      if (bus.addr == MtimecmpOffset + word_t'(8 * h)) rdata_d = mtimecmp_q[h][31:0];
      if (bus.addr == MtimecmpOffset + word_t'(8 * h + 4)) rdata_d = mtimecmp_q[h][63:32];
    end
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      bus.rdata <= '0;
    end else begin
      bus.rdata <= (bus.req && !bus.we) ? rdata_d : '0;
    end
  end

  for (genvar h = 0; h < NumHarts; h++) begin : g_irq
    assign timer_irq_o[h] = mtime_q >= mtimecmp_q[h];
  end

  assign ipi_o = msip_q;

endmodule

// File: design/trace_cfg_regs.sv
module trace_cfg_regs import soc_ctrl_pkg::*; (
  input  logic      clk_i,
  input  logic      ndmreset_n,
  reg_bus_if.device bus,
  output logic      core_sel_o,
  output word_t     watch_addr_o,
  output logic      trig_en_o
);

  logic  wr;
  word_t rdata_d;

  assign wr = bus.req & bus.we;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      core_sel_o   <= 1'b0;
      watch_addr_o <= '0;
      trig_en_o    <= 1'b0;
    end else if (wr) begin
      case (bus.addr)
        CoreSelOffset:   core_sel_o   <= bus.wdata[0];
        WatchAddrOffset: watch_addr_o <= bus.wdata;
        TrigEnOffset:    trig_en_o    <= bus.wdata[0];
        default: ;
      endcase
    end
  end

  always_comb begin
    case (bus.addr)
      CoreSelOffset:   rdata_d = word_t'(core_sel_o);
      WatchAddrOffset: rdata_d = watch_addr_o;
      TrigEnOffset:    rdata_d = word_t'(trig_en_o);
      default:         rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      bus.rdata <= '0;
    end else begin
      bus.rdata <= (bus.req && !bus.we) ? rdata_d : '0;
    end
  end

endmodule

// File: design/cfi_trace_watch.sv
module cfi_trace_watch import soc_ctrl_pkg::*; (
  input  logic        clk_i,
  input  logic        ndmreset_n,
  input  hart_trace_t trace_i [NumHarts],
  input  logic        core_sel_i,
  input  word_t       watch_addr_i,
  input  logic        trig_en_i,
  output logic        trigger_o
);

  hart_trace_t sel_trace;
  logic        hit;

  // Trace of the hart under watch
  assign sel_trace = trace_i[core_sel_i];

  assign hit = trig_en_i & sel_trace.valid & (sel_trace.pc == watch_addr_i);

  // One pulse per matching retired jump
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      trigger_o <= 1'b0;
    end else begin
      trigger_o <= hit;
    end
  end

endmodule

// File: design/debug_req_gate.sv
module debug_req_gate import soc_ctrl_pkg::*; (
  input  logic                clk_i,
  input  logic                ndmreset_n,
  input  logic [NumHarts-1:0] debug_req_i,
  output logic [NumHarts-1:0] debug_req_o
);

  logic [DbgCntWidth-1:0] cnt_q;

  // Window for boot code before debug may halt the harts
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cnt_q <= DbgCntWidth'(DbgDelayCycles);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (cnt_q != '0) ? '0 : debug_req_i;

endmodule

// File: design/ctrl_subsystem.sv
module ctrl_subsystem import soc_ctrl_pkg::*; (
  input  logic                clk_i,
  input  logic                ndmreset_n,
  // Register bus
  input  logic                req_i,
  input  logic                we_i,
  input  word_t               addr_i,
  input  word_t               wdata_i,
  output word_t               rdata_o,
  output logic                decode_err_o,
  // Timer
  input  logic                rtc_i,
  output logic [NumHarts-1:0] timer_irq_o,
  output logic [NumHarts-1:0] ipi_o,
  // Branch-target traces
  input  logic [NumHarts-1:0] trace_valid_i,
  input  word_t               trace_pc_i [NumHarts],
  output logic                trigger_o,
  // Debug
  input  logic [NumHarts-1:0] debug_req_i,
  output logic [NumHarts-1:0] debug_req_o
);

  reg_bus_if clint_bus ();
  reg_bus_if trace_bus ();

  hart_trace_t traces [NumHarts];
  logic        core_sel;
  word_t       watch_addr;
  logic        trig_en;

  for (genvar h = 0; h < NumHarts; h++) begin : g_trace
    assign traces[h] = '{valid: trace_valid_i[h], pc: trace_pc_i[h]};
  end

  // --------------------------------------------------
  // Register bus and devices
  // --------------------------------------------------
  addr_decoder i_addr_decoder (
    .clk_i        ( clk_i        ),
    .ndmreset_n   ( ndmreset_n   ),
    .req_i        ( req_i        ),
    .we_i         ( we_i         ),
    .addr_i       ( addr_i       ),
    .wdata_i      ( wdata_i      ),
    .rdata_o      ( rdata_o      ),
    .decode_err_o ( decode_err_o ),
    .clint_bus    ( clint_bus    ),
    .trace_bus    ( trace_bus    )
  );

  clint_timer i_clint_timer (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .bus         ( clint_bus   ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  trace_cfg_regs i_trace_cfg_regs (
    .clk_i        ( clk_i      ),
    .ndmreset_n   ( ndmreset_n ),
    .bus          ( trace_bus  ),
    .core_sel_o   ( core_sel   ),
    .watch_addr_o ( watch_addr ),
    .trig_en_o    ( trig_en    )
  );

  // --------------------------------------------------
  // Trace watch and debug gate
  // --------------------------------------------------
  cfi_trace_watch i_cfi_trace_watch (
    .clk_i        ( clk_i      ),
    .ndmreset_n   ( ndmreset_n ),
    .trace_i      ( traces     ),
    .core_sel_i   ( core_sel   ),
    .watch_addr_i ( watch_addr ),
    .trig_en_i    ( trig_en    ),
    .trigger_o    ( trigger_o  )
  );

  debug_req_gate i_debug_req_gate (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

// File: tests/tb_ctrl_subsystem.sv
module tb_ctrl_subsystem import soc_ctrl_pkg::*;;

  localparam int ClkPeriod = 20;
  // Debug window dominates the run length
  localparam int WatchdogTime = 3 * DbgDelayCycles * ClkPeriod;

  logic                clk_i;
  logic                ndmreset_n;
  logic                req_i;
  logic                we_i;
  word_t               addr_i;
  word_t               wdata_i;
  word_t               rdata_o;
  logic                decode_err_o;
  logic                rtc_i;
  logic [NumHarts-1:0] timer_irq_o;
  logic [NumHarts-1:0] ipi_o;
  logic [NumHarts-1:0] trace_valid_i;
  word_t               trace_pc_i [NumHarts];
  logic                trigger_o;
  logic [NumHarts-1:0] debug_req_i;
  logic [NumHarts-1:0] debug_req_o;

  int checks;
  int errors;

  ctrl_subsystem dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin
    #(WatchdogTime);
    $display("Timeout: the tests did not finish within %0d time units", WatchdogTime);
    $display("Checks failed");
    $finish;
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  task automatic check_value(input string sig, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("** Error at %0t: %s expected 0x%0h, got 0x%0h", $time, sig, expected, actual);
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    if (errors == err_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d error(s)", name, errors - err_before);
    end
  endtask

  task automatic bus_write(input word_t addr, input word_t data);
    @(posedge clk_i);
    req_i   <= 1'b1;
    we_i    <= 1'b1;
    addr_i  <= addr;
    wdata_i <= data;
    @(posedge clk_i);
    req_i <= 1'b0;
    we_i  <= 1'b0;
  endtask

  // Read data and decode error are valid in the cycle after the request
  task automatic bus_read(input word_t addr, output word_t data, output logic err);
    @(posedge clk_i);
    req_i  <= 1'b1;
    we_i   <= 1'b0;
    addr_i <= addr;
    @(posedge clk_i);
    req_i <= 1'b0;
    @(negedge clk_i);
    data = rdata_o;
    err  = decode_err_o;
  endtask

  task automatic rtc_edges(input int n);
    repeat (n) begin
      @(posedge clk_i);
      rtc_i <= 1'b1;
      repeat (4) @(posedge clk_i);
      rtc_i <= 1'b0;
      repeat (4) @(posedge clk_i);
    end
  endtask

  // Drives one valid trace cycle and samples the trigger in the two cycles after it
  task automatic send_trace(input int hart, input word_t pc, output logic pulse,
                            output logic after);
    @(posedge clk_i);
    trace_valid_i[hart] <= 1'b1;
    trace_pc_i[hart]    <= pc;
    @(posedge clk_i);
    trace_valid_i <= '0;
    @(negedge clk_i);
    pulse = trigger_o;
    @(negedge clk_i);
    after = trigger_o;
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------
  task automatic test_debug_gate();
    int err0;
    err0 = errors;
    repeat (DbgDelayCycles - 1) @(posedge clk_i);
    @(negedge clk_i);
    check_value("debug_req_o", 64'd0, debug_req_o);
    for (int i = 0; i < 4; i++) begin
      @(posedge clk_i);
      @(negedge clk_i);
      check_value("debug_req_o", debug_req_i, debug_req_o);
    end
    report_test("debug gate", err0);
  endtask

  task automatic test_decode();
    int    err0;
    word_t rnd;
    word_t watch;
    word_t rd;
    logic  err;
    err0  = errors;
    watch = $urandom;
    // Core select keeps only bit 0, set so it differs from reset
    rnd   = $urandom | 32'd1;
    bus_write(TraceBase + WatchAddrOffset, watch);
    bus_write(TraceBase + CoreSelOffset, rnd);
    bus_read(TraceBase + WatchAddrOffset, rd, err);
    check_value("rdata_o", watch, rd);
    check_value("decode_err_o", 64'd0, err);
    bus_read(TraceBase + CoreSelOffset, rd, err);
    check_value("rdata_o", 32'd1, rd);
    check_value("decode_err_o", 64'd0, err);
    // mtimecmp comes out of reset as all ones
    bus_read(ClintBase + MtimecmpOffset, rd, err);
    check_value("rdata_o", 32'hFFFF_FFFF, rd);
    check_value("decode_err_o", 64'd0, err);
    bus_read(32'h3000_0000, rd, err);
    check_value("rdata_o", 64'd0, rd);
    check_value("decode_err_o", 64'd1, err);
    report_test("decode", err0);
  endtask

  task automatic test_msip();
    int                  err0;
    logic [NumHarts-1:0] expected;
    err0 = errors;
    for (int h = 0; h < NumHarts; h++) begin
      expected    = '0;
      expected[h] = 1'b1;
      bus_write(ClintBase + MsipOffset + word_t'(4 * h), 32'd1);
      @(negedge clk_i);
      check_value("ipi_o", expected, ipi_o);
      bus_write(ClintBase + MsipOffset + word_t'(4 * h), 32'd0);
      @(negedge clk_i);
      check_value("ipi_o", 64'd0, ipi_o);
    end
    report_test("msip", err0);
  endtask

  task automatic test_timer();
    int    err0;
    int    n;
    word_t rd;
    logic  err;
    err0 = errors;
    n    = 2 + $urandom % 3;
    rtc_edges(2 * n);
    bus_read(ClintBase + MtimeLoOffset, rd, err);
    check_value("rdata_o (mtime low)", n, rd);
    bus_write(ClintBase + MtimecmpOffset + 32'd8, word_t'(n + 2));
    bus_write(ClintBase + MtimecmpOffset + 32'd12, 32'd0);
    @(negedge clk_i);
    check_value("timer_irq_o[1]", 64'd0, timer_irq_o[1]);
    check_value("timer_irq_o[0]", 64'd0, timer_irq_o[0]);
    rtc_edges(4);
    @(negedge clk_i);
    check_value("timer_irq_o[1]", 64'd1, timer_irq_o[1]);
    check_value("timer_irq_o[0]", 64'd0, timer_irq_o[0]);
    report_test("timer", err0);
  endtask

  task automatic test_trace();
    int    err0;
    word_t watch;
    logic  pulse;
    logic  after;
    err0  = errors;
    watch = $urandom;
    bus_write(TraceBase + WatchAddrOffset, watch);
    bus_write(TraceBase + CoreSelOffset, 32'd1);
    bus_write(TraceBase + TrigEnOffset, 32'd1);
    // Hart 0 is not under watch
    send_trace(0, watch, pulse, after);
    check_value("trigger_o", 64'd0, pulse);
    check_value("trigger_o", 64'd0, after);
    send_trace(1, watch, pulse, after);
    check_value("trigger_o", 64'd1, pulse);
    check_value("trigger_o", 64'd0, after);
    bus_write(TraceBase + TrigEnOffset, 32'd0);
    send_trace(1, watch, pulse, after);
    check_value("trigger_o", 64'd0, pulse);
    check_value("trigger_o", 64'd0, after);
    report_test("trace watch", err0);
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    int seed;
    seed          = $urandom(3);
    checks        = 0;
    errors        = 0;
    ndmreset_n    = 1'b0;
    req_i         = 1'b0;
    we_i          = 1'b0;
    addr_i        = '0;
    wdata_i       = '0;
    rtc_i         = 1'b0;
    trace_valid_i = '0;
    debug_req_i   = '1;
    for (int h = 0; h < NumHarts; h++) begin
      trace_pc_i[h] = '0;
    end

    repeat (3) @(posedge clk_i);
    ndmreset_n <= 1'b1;

    test_debug_gate();
    test_decode();
    test_msip();
    test_timer();
    test_trace();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
design/soc_ctrl_pkg.sv
design/reg_bus_if.sv
design/addr_decoder.sv
design/clint_timer.sv
design/trace_cfg_regs.sv
design/cfi_trace_watch.sv
design/debug_req_gate.sv
design/ctrl_subsystem.sv
tests/tb_ctrl_subsystem.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
  --top-module tb_ctrl_subsystem -o sim_ctrl_subsystem
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_ctrl_subsystem)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

echo "$output" | grep -qx "All checks passed" || exit 1
exit 0
